// File: filelist.f
hdl/backend_pkg.sv
hdl/forwarding_unit.sv
hdl/alu.sv
hdl/lsu.sv
hdl/reg_file.sv
hdl/stall_ctrl.sv
hdl/backend_pipeline.sv
hdl/data_ram.sv
hdl/backend_top.sv
dv/tb_backend.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f filelist.f \
	--top-module tb_backend -o tb_backend
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_backend)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
	exit 0
fi
exit 1

// File: dv/tb_backend.sv
`timescale 1ns/1ps

module tb_backend import backend_pkg::*; ();

	localparam int ISSUE_LIMIT = 100; // cycles an issue may wait for ready
	localparam int DRAIN_LIMIT = 200;

	logic              clk;
	logic              rst_n;
	logic              issue_valid_i;
	issue_t            issue_i;
	logic              issue_ready_o;
	logic              reg_w_valid_o;
	logic [REG_AW-1:0] reg_w_addr_o;
	logic [XLEN-1:0]   reg_w_data_o;

	integer seed;
	int     errors;
	int     checks;
	int     tests_run;
	int     tests_failed;
	int     test_err0;
	bit     aborted;
	bit     gaps_on; // random idle cycles between issues

	logic [XLEN-1:0]   model_regs [NREG];
	logic [XLEN-1:0]   model_mem [RAM_WORDS];
	logic [REG_AW-1:0] exp_addr [$];
	logic [XLEN-1:0]   exp_data [$];
	logic [REG_AW-1:0] mon_addr;
	logic [XLEN-1:0]   mon_data;

	backend_top DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.issue_valid_i(issue_valid_i),
		.issue_i      (issue_i),
		.issue_ready_o(issue_ready_o),
		.reg_w_valid_o(reg_w_valid_o),
		.reg_w_addr_o (reg_w_addr_o),
		.reg_w_data_o (reg_w_data_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic issue_t make_instr(op_e op, logic [REG_AW-1:0] rd,
			logic [REG_AW-1:0] rs1, logic [REG_AW-1:0] rs2, logic [IMM_W-1:0] imm);
		return '{op, rd, rs1, rs2, imm};
	endfunction

	function automatic logic [REG_AW-1:0] rand_reg(int lo, int n);
		return REG_AW'(lo + $unsigned($random(seed)) % n);
	endfunction

	// mostly r0..r7 so that hazards are frequent
	function automatic logic [REG_AW-1:0] biased_reg();
		if (($unsigned($random(seed)) % 8) != 0) begin
			return rand_reg(0, 8);
		end
		return rand_reg(0, NREG);
	endfunction

	function automatic logic [IMM_W-1:0] rand_imm();
		return IMM_W'($random(seed));
	endfunction

	function automatic logic [IMM_W-1:0] rand_word_imm();
		return IMM_W'(4 * ($unsigned($random(seed)) % RAM_WORDS));
	endfunction

	// in-order interpreter of one accepted instruction
	task automatic model_exec(issue_t ins);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] res;
		logic            writes;
		a      = model_regs[ins.rs1];
		b      = model_regs[ins.rs2];
		addr   = a + XLEN'($signed(ins.imm));
		res    = '0;
		writes = 1'b1;
		case (ins.op)
			OP_ADD:  res = a + b;
			OP_SUB:  res = a - b;
			OP_AND:  res = a & b;
			OP_OR:   res = a | b;
			OP_XOR:  res = a ^ b;
			OP_SLL:  res = a << b[4:0];
			OP_SRL:  res = a >> b[4:0];
			OP_ADDI: res = addr;
			OP_LW:   res = model_mem[addr[2 +: RAM_AW]];
			OP_SW: begin
				model_mem[addr[2 +: RAM_AW]] = b;
				writes = 1'b0;
			end
			default: writes = 1'b0;
		endcase
		if (writes && ins.rd != '0) begin
			model_regs[ins.rd] = res;
			exp_addr.push_back(ins.rd);
			exp_data.push_back(res);
		end
	endtask

	task automatic issue(issue_t ins);
		int waited;
		int gap;
		bit taken;
		if (aborted) begin
			return;
		end
		gap = 0;
		if (gaps_on && ($unsigned($random(seed)) % 4) == 0) begin
			gap = 1 + $unsigned($random(seed)) % 3;
		end
		repeat (gap) begin
			@(negedge clk);
			issue_valid_i = 1'b0;
		end
		waited = 0;
		taken  = 1'b0;
		while (!taken && waited < ISSUE_LIMIT) begin
			@(negedge clk);
			issue_valid_i = 1'b1;
			issue_i       = ins;
			taken         = issue_ready_o; // stable until the next rising edge
			waited++;
		end
		if (taken) begin
			model_exec(ins);
		end else begin
			$display("timeout: instruction not accepted within %0d cycles", ISSUE_LIMIT);
			errors++;
			aborted = 1'b1;
		end
	endtask

	task automatic drain();
		int waited;
		if (aborted) begin
			return;
		end
		@(negedge clk);
		issue_valid_i = 1'b0;
		waited = 0;
		while (exp_addr.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (exp_addr.size() != 0) begin
			$display("timeout: %0d expected register writes never arrived", exp_addr.size());
			errors++;
			aborted = 1'b1;
		end
		repeat (6) @(posedge clk); // let any extra write show up
	endtask

	task automatic test_start();
		test_err0 = errors;
		tests_run++;
	endtask

	task automatic test_end(string name);
		drain();
		if (errors == test_err0) begin
			$display("test %0d %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed, %0d errors", tests_run, name, errors - test_err0);
		end
	endtask

	// writeback monitor, outputs settle well before the falling edge
	always @(negedge clk) begin
		if (rst_n && reg_w_valid_o) begin
			checks++;
			assert (reg_w_addr_o != '0) else begin
				$display("register 0 write reported on the writeback port");
				errors++;
			end
			assert (exp_addr.size() != 0) else begin
				$display("unexpected register write to r%0d, none outstanding", reg_w_addr_o);
				errors++;
			end
			if (exp_addr.size() != 0) begin
				mon_addr = exp_addr.pop_front();
				mon_data = exp_data.pop_front();
				assert (reg_w_addr_o == mon_addr) else begin
					$display("** Error reg_w_addr_o expected %h got %h", mon_addr, reg_w_addr_o);
					errors++;
				end
				assert (reg_w_data_o == mon_data) else begin
					$display("** Error reg_w_data_o expected %h got %h", mon_data, reg_w_data_o);
					errors++;
				end
			end
		end
	end

	initial begin
		logic [REG_AW-1:0] rd;
		logic [IMM_W-1:0]  off;
		seed          = 89;
		errors        = 0;
		checks        = 0;
		tests_run     = 0;
		tests_failed  = 0;
		aborted       = 1'b0;
		gaps_on       = 1'b1;
		rst_n         = 1'b0;
		issue_valid_i = 1'b0;
		issue_i       = '0;
		for (int i = 0; i < NREG; i++) begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < RAM_WORDS; i++) begin
			model_mem[i] = '0;
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		test_start();
		// pipeline empty straight out of reset
		assert (issue_ready_o == 1'b1) else begin
			$display("** Error issue_ready_o expected %h got %h", 1'b1, issue_ready_o);
			errors++;
		end
		assert (reg_w_valid_o == 1'b0) else begin
			$display("** Error reg_w_valid_o expected %h got %h", 1'b0, reg_w_valid_o);
			errors++;
		end
		for (int r = 1; r < 8; r++) begin
			issue(make_instr(OP_ADDI, REG_AW'(r), 5'd0, 5'd0, rand_imm()));
		end
		for (int i = 0; i < 20; i++) begin
			issue(make_instr(op_e'(1 + $unsigned($random(seed)) % 8), rand_reg(1, 7),
				rand_reg(0, 8), rand_reg(0, 8), rand_imm()));
			repeat (3) issue(make_instr(OP_NOP, 5'd0, 5'd0, 5'd0, 12'd0));
		end
		test_end("independent alu ops");

		test_start();
		gaps_on = 1'b0; // back to back so m1 forwarding is hit
		for (int i = 0; i < 40; i++) begin
			issue(make_instr(op_e'(1 + $unsigned($random(seed)) % 8), rand_reg(1, 3),
				rand_reg(1, 3), rand_reg(1, 3), rand_imm()));
		end
		test_end("dependent alu chain");

		test_start();
		for (int w = 0; w < 4; w++) begin
			off = IMM_W'(4 * w); // address bits 3:2 pick the wait states
			issue(make_instr(OP_ADDI, 5'd5, 5'd0, 5'd0, IMM_W'(16 * ($unsigned($random(seed)) % 4))));
			issue(make_instr(OP_ADDI, 5'd6, 5'd0, 5'd0, rand_imm()));
			issue(make_instr(OP_SW, 5'd0, 5'd5, 5'd6, off));
			issue(make_instr(OP_LW, 5'd7, 5'd5, 5'd0, off));
		end
		test_end("store then load");

		test_start();
		for (int i = 0; i < 6; i++) begin
			issue(make_instr(OP_ADDI, 5'd1, 5'd0, 5'd0, rand_imm()));
			issue(make_instr(OP_SW, 5'd0, 5'd0, 5'd1, rand_word_imm()));
		end
		for (int i = 0; i < 12; i++) begin
			rd = rand_reg(1, 7);
			issue(make_instr(OP_LW, rd, 5'd0, 5'd0, rand_word_imm()));
			case ($unsigned($random(seed)) % 3)
				0: issue(make_instr(OP_ADD, rand_reg(1, 7), rd, rand_reg(0, 8), 12'd0));
				1: issue(make_instr(OP_SW, 5'd0, 5'd0, rd, rand_word_imm()));
				default: issue(make_instr(OP_LW, rand_reg(1, 7), rd, 5'd0, 12'd0));
			endcase
		end
		test_end("load use");

		test_start();
		issue(make_instr(OP_ADDI, 5'd0, 5'd0, 5'd0, rand_imm()));
		issue(make_instr(OP_ADD, 5'd0, 5'd1, 5'd2, 12'd0));
		issue(make_instr(OP_LW, 5'd0, 5'd0, 5'd0, rand_word_imm()));
		issue(make_instr(OP_ADD, 5'd3, 5'd0, 5'd0, 12'd0));
		issue(make_instr(OP_ADDI, 5'd4, 5'd0, 5'd0, rand_imm()));
		issue(make_instr(OP_OR, 5'd5, 5'd0, 5'd4, 12'd0));
		test_end("register zero");

		test_start();
		gaps_on = 1'b1;
		for (int i = 0; i < 600; i++) begin
			issue(make_instr(op_e'($unsigned($random(seed)) % 11), biased_reg(),
				biased_reg(), biased_reg(), rand_imm()));
		end
		test_end("random mix");

		$display("tests %0d, failed %0d, writes checked %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && !aborted) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: hdl/backend_top.sv
`timescale 1ns/1ps

module backend_top import backend_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              issue_valid_i,
	input  issue_t            issue_i,
	output logic              issue_ready_o,
	output logic              reg_w_valid_o,
	output logic [REG_AW-1:0] reg_w_addr_o,
	output logic [XLEN-1:0]   reg_w_data_o
);

	logic [1:0][REG_AW-1:0] rf_raddr;
	logic [1:0][XLEN-1:0]   rf_rdata;
	logic [2:0]             stall_vec;
	logic [2:0]             clr_vec;
	logic                   ex_stall_req;
	logic                   m2_stall_req;
	apb_req_t               apb_req;
	apb_resp_t              apb_resp;

	backend_pipeline u_pipeline (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue_valid_i (issue_valid_i),
		.issue_i       (issue_i),
		.issue_ready_o (issue_ready_o),
		.rf_raddr_o    (rf_raddr),
		.rf_rdata_i    (rf_rdata),
		.stall_vec_i   (stall_vec),
		.clr_vec_i     (clr_vec),
		.ex_stall_req_o(ex_stall_req),
		.m2_stall_req_o(m2_stall_req),
		.apb_req_o     (apb_req),
		.apb_resp_i    (apb_resp),
		.reg_w_valid_o (reg_w_valid_o),
		.reg_w_addr_o  (reg_w_addr_o),
		.reg_w_data_o  (reg_w_data_o)
	);

	// wb port doubles as the register file write
	reg_file u_reg_file (
		.clk    (clk),
		.rst_n  (rst_n),
		.raddr_i(rf_raddr),
		.rdata_o(rf_rdata),
		.we_i   (reg_w_valid_o),
		.waddr_i(reg_w_addr_o),
		.wdata_i(reg_w_data_o)
	);

	stall_ctrl u_stall_ctrl (
		.ex_stall_req_i(ex_stall_req),
		.m2_stall_req_i(m2_stall_req),
		.stall_vec_o   (stall_vec),
		.clr_vec_o     (clr_vec)
	);

	data_ram u_data_ram (
		.clk       (clk),
		.rst_n     (rst_n),
		.apb_req_i (apb_req),
		.apb_resp_o(apb_resp)
	);

endmodule

// File: hdl/data_ram.sv
`timescale 1ns/1ps

module data_ram import backend_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  apb_req_t  apb_req_i,
	output apb_resp_t apb_resp_o
);

	logic [XLEN-1:0]   mem [RAM_WORDS];
	logic [1:0]        wait_cnt;
	logic [RAM_AW-1:0] idx;
	logic              access;
	logic              ready;

	assign idx    = apb_req_i.paddr[2 +: RAM_AW]; // wraps at 64 words
	assign access = apb_req_i.psel & apb_req_i.penable;
	// wait cycles set by address bits 3:2
	assign ready  = access && (wait_cnt == apb_req_i.paddr[3:2]);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wait_cnt <= '0;
			for (int i = 0; i < RAM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (ready) begin
			wait_cnt <= '0;
			if (apb_req_i.pwrite) begin
				mem[idx] <= apb_req_i.pwdata;
			end
		end else if (access) begin
			wait_cnt <= wait_cnt + 2'd1;
		end else begin
			wait_cnt <= '0;
		end
	end

	assign apb_resp_o.pready = ready;
	assign apb_resp_o.prdata = (ready && !apb_req_i.pwrite) ? mem[idx] : '0;

endmodule

// File: hdl/backend_pipeline.sv
`timescale 1ns/1ps

module backend_pipeline import backend_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   issue_valid_i,
	input  issue_t                 issue_i,
	output logic                   issue_ready_o,
	output logic [1:0][REG_AW-1:0] rf_raddr_o,   // 0 rs1, 1 rs2
	input  logic [1:0][XLEN-1:0]   rf_rdata_i,
	input  logic [2:0]             stall_vec_i,  // 0 ex, 1 m1, 2 m2
	input  logic [2:0]             clr_vec_i,
	output logic                   ex_stall_req_o,
	output logic                   m2_stall_req_o,
	output apb_req_t               apb_req_o,
	input  apb_resp_t              apb_resp_i,
	output logic                   reg_w_valid_o,
	output logic [REG_AW-1:0]      reg_w_addr_o,
	output logic [XLEN-1:0]        reg_w_data_o
);

	ctrl_flow_t issue_ctrl;
	ctrl_flow_t ex_ctrl, m1_ctrl, m2_ctrl, wb_ctrl;
	data_flow_t ex_raw, ex_fwd, m1_raw, m1_fwd, m2_raw, m2_fwd, wb_data;
	logic [1:0][XLEN-1:0] issue_data;
	logic [XLEN-1:0] alu_result;
	logic [XLEN-1:0] lsu_rdata;
	logic issue_fire;

	function automatic wb_sel_e wb_sel_of(op_e op);
		case (op)
			OP_NOP, OP_SW: return WB_NONE;
			OP_LW:         return WB_LSU;
			default:       return WB_ALU;
		endcase
	endfunction

	function automatic logic reads_rs2(op_e op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SW};
	endfunction

	// a load ahead of ex whose target ex still needs
	function automatic logic load_use(ctrl_flow_t ld, ctrl_flow_t ex);
		logic hit_rs1;
		logic hit_rs2;
		hit_rs1 = (ex.op != OP_NOP) && (ex.rs1 == ld.rd);
		hit_rs2 = reads_rs2(ex.op) && (ex.rs2 == ld.rd);
		return ld.valid && ld.wb_sel == WB_LSU && ld.rd != '0 && ex.valid && (hit_rs1 || hit_rs2);
	endfunction

	assign issue_ready_o = ~stall_vec_i[0];
	assign issue_fire    = issue_valid_i & issue_ready_o;
	assign rf_raddr_o    = {issue_i.rs2, issue_i.rs1};

	assign issue_ctrl = '{
		valid:  1'b1,
		op:     issue_i.op,
		wb_sel: wb_sel_of(issue_i.op),
		rd:     issue_i.rd,
		rs1:    issue_i.rs1,
		rs2:    issue_i.rs2,
		imm:    issue_i.imm
	};

	// wb writes the file on the same edge ex captures, so bypass it here
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			if (reg_w_valid_o && reg_w_addr_o == rf_raddr_o[i]) begin
				issue_data[i] = reg_w_data_o;
			end else begin
				issue_data[i] = rf_rdata_i[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_ctrl <= '0;
		end else if (!stall_vec_i[0]) begin
			ex_ctrl <= issue_fire ? issue_ctrl : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m1_ctrl <= '0;
		end else if (!stall_vec_i[1]) begin
			m1_ctrl <= clr_vec_i[0] ? '0 : ex_ctrl; // load-use bubble
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m2_ctrl <= '0;
		end else if (!stall_vec_i[2]) begin
			m2_ctrl <= clr_vec_i[1] ? '0 : m1_ctrl;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ctrl <= '0;
		end else begin
			wb_ctrl <= clr_vec_i[2] ? '0 : m2_ctrl;
		end
	end

	// held stages pick up forwarded values while they wait
	always_ff @(posedge clk) begin
		if (!stall_vec_i[0]) begin
			ex_raw.reg_data <= issue_data;
			ex_raw.result   <= '0;
		end else begin
			ex_raw <= ex_fwd;
		end
	end

	always_ff @(posedge clk) begin
		m1_raw <= stall_vec_i[1] ? m1_fwd : ex_fwd;
		if (stall_vec_i[2]) begin
			m2_raw.reg_data <= m2_fwd.reg_data; // address in result stays put
		end else begin
			m2_raw <= m1_fwd;
		end
		wb_data <= m2_fwd;
	end

	// only stages older than the consumer are sources
	for (genvar i = 0; i < 2; i++) begin : g_fwd
		forwarding_unit u_ex_fwd (
			.reg_i      (i == 0 ? ex_ctrl.rs1 : ex_ctrl.rs2),
			.old_data_i (ex_raw.reg_data[i]),
			.m1_ctrl_i  (m1_ctrl),
			.m1_result_i(m1_fwd.result),
			.m2_ctrl_i  (m2_ctrl),
			.m2_result_i(m2_fwd.result),
			.wb_ctrl_i  (wb_ctrl),
			.wb_result_i(wb_data.result),
			.new_data_o (ex_fwd.reg_data[i])
		);

		forwarding_unit u_m1_fwd (
			.reg_i      (i == 0 ? m1_ctrl.rs1 : m1_ctrl.rs2),
			.old_data_i (m1_raw.reg_data[i]),
			.m1_ctrl_i  ('0),
			.m1_result_i('0),
			.m2_ctrl_i  (m2_ctrl),
			.m2_result_i(m2_fwd.result),
			.wb_ctrl_i  (wb_ctrl),
			.wb_result_i(wb_data.result),
			.new_data_o (m1_fwd.reg_data[i])
		);

		forwarding_unit u_m2_fwd (
			.reg_i      (i == 0 ? m2_ctrl.rs1 : m2_ctrl.rs2),
			.old_data_i (m2_raw.reg_data[i]),
			.m1_ctrl_i  ('0),
			.m1_result_i('0),
			.m2_ctrl_i  ('0),
			.m2_result_i('0),
			.wb_ctrl_i  (wb_ctrl),
			.wb_result_i(wb_data.result),
			.new_data_o (m2_fwd.reg_data[i])
		);
	end

	alu u_alu (
		.op_i    (ex_ctrl.op),
		.a_i     (ex_fwd.reg_data[0]),
		.b_i     (ex_fwd.reg_data[1]),
		.imm_i   (ex_ctrl.imm),
		.result_o(alu_result)
	);

	assign ex_fwd.result = alu_result;
	assign m1_fwd.result = m1_raw.result;
	assign m2_fwd.result = (m2_ctrl.wb_sel == WB_LSU) ? lsu_rdata : m2_raw.result;

	lsu u_lsu (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctrl_i    (m2_ctrl),
		.addr_i    (m2_raw.result),       // address from ex
		.wdata_i   (m2_fwd.reg_data[1]),
		.rdata_o   (lsu_rdata),
		.busy_o    (m2_stall_req_o),
		.apb_req_o (apb_req_o),
		.apb_resp_i(apb_resp_i)
	);

	assign ex_stall_req_o = load_use(m1_ctrl, ex_ctrl) | load_use(m2_ctrl, ex_ctrl);

	assign reg_w_valid_o = wb_ctrl.valid && wb_ctrl.wb_sel != WB_NONE && wb_ctrl.rd != '0;
	assign reg_w_addr_o  = wb_ctrl.rd;
	assign reg_w_data_o  = wb_data.result;

endmodule

// File: hdl/stall_ctrl.sv
`timescale 1ns/1ps

module stall_ctrl (
	input  logic       ex_stall_req_i,
	input  logic       m2_stall_req_i,
	output logic [2:0] stall_vec_o,   // 0 ex, 1 m1, 2 m2
	output logic [2:0] clr_vec_o      // bit i clears the stage after stage i
);

	always_comb begin
		// a request stalls its own stage and every earlier one
		stall_vec_o[0] = ex_stall_req_i | m2_stall_req_i;
		stall_vec_o[1] = m2_stall_req_i; // m1 never asks
		stall_vec_o[2] = m2_stall_req_i;

		// bubble into the first stage that keeps moving
		clr_vec_o[0] = stall_vec_o[0] & ~stall_vec_o[1];
		clr_vec_o[1] = stall_vec_o[1] & ~stall_vec_o[2];
		clr_vec_o[2] = stall_vec_o[2];
	end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file import backend_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [1:0][REG_AW-1:0] raddr_i,
	output logic [1:0][XLEN-1:0]   rdata_o,
	input  logic                   we_i,
	input  logic [REG_AW-1:0]      waddr_i,
	input  logic [XLEN-1:0]        wdata_i
);

	logic [XLEN-1:0] regs [NREG];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// no write-through, same-cycle reads see the old value
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			rdata_o[i] = (raddr_i[i] == '0) ? '0 : regs[raddr_i[i]];
		end
	end

endmodule

// File: hdl/lsu.sv
`timescale 1ns/1ps

module lsu import backend_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  ctrl_flow_t      ctrl_i,   // m2 stage control
	input  logic [XLEN-1:0] addr_i,
	input  logic [XLEN-1:0] wdata_i,
	output logic [XLEN-1:0] rdata_o,
	output logic            busy_o,
	output apb_req_t        apb_req_o,
	input  apb_resp_t       apb_resp_i
);

	typedef enum logic {
		ST_IDLE,
		ST_ACCESS
	} lsu_state_e;

	lsu_state_e state_q, state_d;
	logic mem_op;
	logic start;
	logic done_q;   // transfer just finished

	assign mem_op = ctrl_i.valid && (ctrl_i.op == OP_LW || ctrl_i.op == OP_SW);

	// setup phase happens in the idle cycle that starts a transfer
	assign start = (state_q == ST_IDLE) && mem_op && !done_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (start) begin
					state_d = ST_ACCESS;
				end
			end
			ST_ACCESS: begin
				if (apb_resp_i.pready) begin
					state_d = ST_IDLE;
				end
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
			done_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			// one quiet cycle before the next transfer may start
			done_q  <= (state_q == ST_ACCESS) && apb_resp_i.pready;
		end
	end

	// m2 is held for the whole transfer, released in the pready cycle
	assign busy_o = (state_q == ST_ACCESS) ? !apb_resp_i.pready : mem_op;

	assign apb_req_o.psel    = start || (state_q == ST_ACCESS);
	assign apb_req_o.penable = (state_q == ST_ACCESS);
	assign apb_req_o.pwrite  = (ctrl_i.op == OP_SW);
	assign apb_req_o.paddr   = addr_i;
	assign apb_req_o.pwdata  = wdata_i;

	assign rdata_o = apb_resp_i.prdata; // valid in the completing cycle

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu import backend_pkg::*; (
	input  op_e              op_i,
	input  logic [XLEN-1:0]  a_i,
	input  logic [XLEN-1:0]  b_i,
	input  logic [IMM_W-1:0] imm_i,
	output logic [XLEN-1:0]  result_o
);

	logic [XLEN-1:0] imm_ext;

	assign imm_ext = {{(XLEN-IMM_W){imm_i[IMM_W-1]}}, imm_i};

	always_comb begin
		case (op_i)
			OP_ADD:  result_o = a_i + b_i;
			OP_SUB:  result_o = a_i - b_i;
			OP_AND:  result_o = a_i & b_i;
			OP_OR:   result_o = a_i | b_i;
			OP_XOR:  result_o = a_i ^ b_i;
			OP_SLL:  result_o = a_i << b_i[4:0];
			OP_SRL:  result_o = a_i >> b_i[4:0]; // logical
			OP_ADDI: result_o = a_i + imm_ext;
			// byte address, carried to m2 in the result field
			OP_LW,
			OP_SW:   result_o = a_i + imm_ext;
			default: result_o = '0;
		endcase
	end

endmodule

// File: hdl/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit import backend_pkg::*; (
	input  logic [REG_AW-1:0] reg_i,
	input  logic [XLEN-1:0]   old_data_i,
	input  ctrl_flow_t        m1_ctrl_i,
	input  logic [XLEN-1:0]   m1_result_i,
	input  ctrl_flow_t        m2_ctrl_i,
	input  logic [XLEN-1:0]   m2_result_i,
	input  ctrl_flow_t        wb_ctrl_i,
	input  logic [XLEN-1:0]   wb_result_i,
	output logic [XLEN-1:0]   new_data_o
);

	// oldest first, so the youngest match wins
	always_comb begin
		new_data_o = old_data_i;
		if (reg_i != '0) begin
			if (wb_ctrl_i.valid && wb_ctrl_i.wb_sel != WB_NONE && wb_ctrl_i.rd == reg_i) begin
				new_data_o = wb_result_i;
			end
			// loads have no data yet in m1/m2
			if (m2_ctrl_i.valid && m2_ctrl_i.wb_sel == WB_ALU && m2_ctrl_i.rd == reg_i) begin
				new_data_o = m2_result_i;
			end
			if (m1_ctrl_i.valid && m1_ctrl_i.wb_sel == WB_ALU && m1_ctrl_i.rd == reg_i) begin
				new_data_o = m1_result_i;
			end
		end
	end

endmodule

// File: hdl/backend_pkg.sv
package backend_pkg;

	localparam int XLEN      = 32;
	localparam int NREG      = 32;
	localparam int RAM_WORDS = 64;
	localparam int REG_AW    = $clog2(NREG);      // register number width
	localparam int RAM_AW    = $clog2(RAM_WORDS); // data memory word index
	localparam int IMM_W     = 12;

	typedef enum logic [3:0] {
		OP_NOP,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLL,
		OP_SRL,
		OP_ADDI,
		OP_LW,
		OP_SW
	} op_e;

	typedef enum logic [1:0] {
		WB_NONE,
		WB_ALU,
		WB_LSU
	} wb_sel_e;

	typedef struct packed {
		op_e              op;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] rs1;
		logic [REG_AW-1:0] rs2;
		logic [IMM_W-1:0]  imm;
	} issue_t;

	typedef struct packed {
		logic              valid;
		op_e               op;
		wb_sel_e           wb_sel;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] rs1;
		logic [REG_AW-1:0] rs2;
		logic [IMM_W-1:0]  imm;
	} ctrl_flow_t;

	// reg_data[0] is rs1, reg_data[1] is rs2 (store data)
	typedef struct packed {
		logic [1:0][XLEN-1:0] reg_data;
		logic [XLEN-1:0]      result;
	} data_flow_t;

	typedef struct packed {
		logic            psel;
		logic            penable;
		logic            pwrite;
		logic [XLEN-1:0] paddr;
		logic [XLEN-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [XLEN-1:0] prdata;
		logic            pready;
	} apb_resp_t;

endpackage
